// ==== stream_consts.svh ====
// Matrix streamer constants
// Word, address and length widths, load FIFO depth and cast mode codes
// shared by every block of the data streamer

`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Memory word and stream beat width
`define STREAM_DATA_W 32
// Word address width
`define STREAM_ADDR_W 12
// Transfer length in memory words
`define STREAM_LEN_W 8
// Entries in each load response FIFO
`define STREAM_FIFO_DEPTH 4

// Cast modes
`define STREAM_CAST_OFF 1'b0
`define STREAM_CAST_FP8 1'b1

`endif

// ==== stream_pkg.sv ====
// Matrix streamer types
// Memory word seen as FP16 or FP8 lanes, and the arbiter channel index

`default_nettype none

package stream_pkg;

  // One memory word
  // Two FP16 lanes or four FP8 (E5M2) lanes, lane 0 in the low bits
  typedef union packed {
    logic [1:0][15:0] fp16;
    logic [3:0][7:0]  fp8;
  } mem_word_u;

  // Arbiter channels
  // Loads first, the store channel last
  typedef enum logic [1:0] {
    CH_X = 2'd0,
    CH_W = 2'd1,
    CH_Y = 2'd2,
    CH_Z = 2'd3
  } chan_e;

endpackage

`default_nettype wire

// ==== mem_arbiter.sv ====
// Memory port arbiter
// Round-robin choice among the four streamer channels for the shared
// request/grant port, read data routed back one cycle after the grant

`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module mem_arbiter (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  // Channel side
  input  wire  [3:0]                     req_i,
  input  wire  [3:0]                     we_i,
  input  wire  [3:0][`STREAM_ADDR_W-1:0] addr_i,
  input  wire  [3:0][`STREAM_DATA_W-1:0] wdata_i,
  output logic [3:0]                     gnt_o,
  output logic [3:0]                     rvalid_o,
  output logic [`STREAM_DATA_W-1:0]      rdata_o,
  // Memory side
  output logic                           mem_req_o,
  output logic                           mem_we_o,
  output logic [`STREAM_ADDR_W-1:0]      mem_addr_o,
  output logic [`STREAM_DATA_W-1:0]      mem_wdata_o,
  input  wire                            mem_gnt_i,
  input  wire                            mem_rvalid_i,
  input  wire  [`STREAM_DATA_W-1:0]      mem_rdata_i
);

  // Last granted channel, the search starts right after it
  stream_pkg::chan_e last_q;
  // Channel of the read that got its grant last cycle
  stream_pkg::chan_e rd_idx_q;
  logic              rd_pend_q;
  stream_pkg::chan_e win;
  logic              any_req;
  logic [1:0]        cand;
  logic              fire;

  // Rotating priority search
  // offset 4 wraps back onto last_q so it ranks lowest
  always_comb begin
    win     = last_q;
    any_req = 1'b0;
    cand    = 2'd0;
    for (int i = 1; i <= 4; i++) begin
      cand = 2'(last_q) + 2'(i);
      if (!any_req && req_i[cand]) begin
        any_req = 1'b1;
        win     = stream_pkg::chan_e'(cand);
      end
    end
  end

  // Winner goes onto the memory port
  assign mem_req_o   = any_req;
  assign mem_we_o    = we_i[win];
  assign mem_addr_o  = addr_i[win];
  assign mem_wdata_o = wdata_i[win];
  assign fire        = any_req && mem_gnt_i;

  // Memory grant handed to the winner only
  always_comb begin
    gnt_o = '0;
    if (fire) gnt_o[win] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q    <= stream_pkg::CH_Z;
      rd_idx_q  <= stream_pkg::CH_X;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= fire && !we_i[win];
      if (fire) begin
        last_q   <= win;
        rd_idx_q <= win;
      end
    end
  end

  // Read response steered by the registered index
  always_comb begin
    rvalid_o = '0;
    if (mem_rvalid_i && rd_pend_q) rvalid_o[rd_idx_q] = 1'b1;
  end
  assign rdata_o = mem_rdata_i;

  a_gnt_onehot0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o));

  // Memory answers only granted reads, so every response finds its channel
  a_rsp_routed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rvalid_i |-> $onehot(rvalid_o));

endmodule

`default_nettype wire

// ==== load_source.sv ====
// Load channel
// Reads a block of consecutive words through the arbiter, buffers the
// responses and streams them out, optionally widening FP8 lanes to FP16
// Requests are credit limited so the FIFO can always take a response

`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module load_source (
  input  wire                         clk_i,
  input  wire                         rst_n_i,
  // Run control
  input  wire                         start_i,
  input  wire                         cast_i,
  input  wire  [`STREAM_ADDR_W-1:0]   base_i,
  input  wire  [`STREAM_LEN_W-1:0]    len_i,
  // Arbiter side
  output logic                        req_o,
  output logic [`STREAM_ADDR_W-1:0]   addr_o,
  input  wire                         gnt_i,
  input  wire                         rvalid_i,
  input  wire  [`STREAM_DATA_W-1:0]   rdata_i,
  // Stream to the engine
  output logic [`STREAM_DATA_W-1:0]   data_o,
  output logic                        valid_o,
  input  wire                         ready_i,
  // Status
  output logic                        busy_o,
  output logic                        done_o
);

  localparam int DEPTH = `STREAM_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // Run state
  logic                      busy_q;
  logic                      cast_q;
  logic                      done_q;
  logic [`STREAM_ADDR_W-1:0] addr_q;
  // Reads still to issue, words still to hand out
  logic [`STREAM_LEN_W-1:0]  req_left_q;
  logic [`STREAM_LEN_W-1:0]  word_left_q;
  // Granted reads whose data has not come back
  logic [CNT_W-1:0]          pend_q;

  // Response FIFO
  logic [`STREAM_DATA_W-1:0] fifo_mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [CNT_W-1:0]          fifo_cnt_q;
  // Selects the upper FP8 pair of the head word in cast mode
  logic                      half_q;

  logic [CNT_W:0]            used;
  logic                      credit_ok;
  logic                      fire;
  logic                      push;
  logic                      pop_beat;
  logic                      pop_word;
  logic                      last_word;
  stream_pkg::mem_word_u     head;
  stream_pkg::mem_word_u     beat;

  // Credits count stored words plus reads in flight
  assign used      = {1'b0, fifo_cnt_q} + {1'b0, pend_q};
  assign credit_ok = used < (CNT_W+1)'(DEPTH);
  assign req_o     = busy_q && (req_left_q != '0) && credit_ok;
  assign addr_o    = addr_q;
  assign fire      = req_o && gnt_i;
  assign push      = rvalid_i;

  // Stream handshake
  assign valid_o   = fifo_cnt_q != '0;
  assign pop_beat  = valid_o && ready_i;
  // In cast mode a word leaves after its second beat
  assign pop_word  = pop_beat && (!cast_q || half_q);
  assign last_word = pop_word && (word_left_q == `STREAM_LEN_W'(1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      cast_q      <= `STREAM_CAST_OFF;
      done_q      <= 1'b0;
      addr_q      <= '0;
      req_left_q  <= '0;
      word_left_q <= '0;
      pend_q      <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      fifo_cnt_q  <= '0;
      half_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      // New run, ignored while one is going
      if (start_i && !busy_q) begin
        busy_q      <= 1'b1;
        cast_q      <= cast_i;
        addr_q      <= base_i;
        req_left_q  <= len_i;
        word_left_q <= len_i;
        half_q      <= 1'b0;
      end
      if (fire) begin
        addr_q     <= addr_q + 1'b1;
        req_left_q <= req_left_q - 1'b1;
      end
      pend_q     <= pend_q + CNT_W'(fire) - CNT_W'(push);
      fifo_cnt_q <= fifo_cnt_q + CNT_W'(push) - CNT_W'(pop_word);
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_word) begin
        rd_ptr_q    <= rd_ptr_q + 1'b1;
        word_left_q <= word_left_q - 1'b1;
      end
      if (pop_beat && cast_q) half_q <= !half_q;
      if (last_word) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // FIFO storage
  always_ff @(posedge clk_i) begin
    if (push) fifo_mem[wr_ptr_q] <= rdata_i;
  end

  // Head word decode
  // FP8 byte becomes the upper byte of an FP16 lane, low pair first
  assign head = fifo_mem[rd_ptr_q];
  always_comb begin
    beat = head;
    if (cast_q) begin
      beat.fp16[0] = {head.fp8[{half_q, 1'b0}], 8'h00};
      beat.fp16[1] = {head.fp8[{half_q, 1'b1}], 8'h00};
    end
  end

  assign data_o = beat;
  assign busy_o = busy_q;
  assign done_o = done_q;

  // Arbiter routing and credits together keep the FIFO from overflowing
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> (fifo_cnt_q < CNT_W'(DEPTH)));

endmodule

`default_nettype wire

// ==== store_sink.sv ====
// Store channel
// Collects result beats from the engine into memory words, narrowing
// FP16 lanes to FP8 when cast is on, and writes them to consecutive
// addresses through the arbiter

`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module store_sink (
  input  wire                         clk_i,
  input  wire                         rst_n_i,
  // Run control
  input  wire                         start_i,
  input  wire                         cast_i,
  input  wire  [`STREAM_ADDR_W-1:0]   base_i,
  input  wire  [`STREAM_LEN_W-1:0]    len_i,
  // Arbiter side
  output logic                        req_o,
  output logic                        we_o,
  output logic [`STREAM_ADDR_W-1:0]   addr_o,
  output logic [`STREAM_DATA_W-1:0]   wdata_o,
  input  wire                         gnt_i,
  // Stream from the engine
  input  wire  [`STREAM_DATA_W-1:0]   data_i,
  input  wire                         valid_i,
  output logic                        ready_o,
  // Status
  output logic                        busy_o,
  output logic                        done_o
);

  logic                      busy_q;
  logic                      cast_q;
  logic                      done_q;
  logic [`STREAM_ADDR_W-1:0] addr_q;
  // Words not yet granted
  logic [`STREAM_LEN_W-1:0]  word_left_q;
  // Low FP8 pair already filled
  logic                      half_q;
  // Complete word waiting for its grant
  logic                      full_q;
  stream_pkg::mem_word_u     pack_q;
  stream_pkg::mem_word_u     in_w;
  logic                      take;
  logic                      fire;

  assign in_w    = data_i;
  // Engine stalls while a word waits on memory
  assign ready_o = busy_q && !full_q;
  assign take    = valid_i && ready_o;
  assign fire    = full_q && gnt_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      cast_q      <= `STREAM_CAST_OFF;
      done_q      <= 1'b0;
      addr_q      <= '0;
      word_left_q <= '0;
      half_q      <= 1'b0;
      full_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i && !busy_q) begin
        busy_q      <= 1'b1;
        cast_q      <= cast_i;
        addr_q      <= base_i;
        word_left_q <= len_i;
        half_q      <= 1'b0;
      end
      // Word complete after one beat, or two in cast mode
      if (take) begin
        half_q <= cast_q && !half_q;
        if (!cast_q || half_q) full_q <= 1'b1;
      end
      if (fire) begin
        full_q      <= 1'b0;
        addr_q      <= addr_q + 1'b1;
        word_left_q <= word_left_q - 1'b1;
        if (word_left_q == `STREAM_LEN_W'(1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Word assembly
  // FP16 truncated to its upper byte, first beat into the low lanes
  always_ff @(posedge clk_i) begin
    if (take) begin
      if (!cast_q) begin
        pack_q <= in_w;
      end else if (!half_q) begin
        pack_q.fp8[0] <= in_w.fp16[0][15:8];
        pack_q.fp8[1] <= in_w.fp16[1][15:8];
      end else begin
        pack_q.fp8[2] <= in_w.fp16[0][15:8];
        pack_q.fp8[3] <= in_w.fp16[1][15:8];
      end
    end
  end

  assign req_o   = full_q;
  assign we_o    = 1'b1;
  assign addr_o  = addr_q;
  assign wdata_o = pack_q;
  assign busy_o  = busy_q;
  assign done_o  = done_q;

  // Request held with the same word until the arbiter grants it
  a_wdata_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_o && !gnt_i |=> req_o && $stable(wdata_o));

endmodule

`default_nettype wire

// ==== streamer.sv ====
// Matrix streamer top level
// Three load channels (X, W, Y) and one store channel (Z) sharing one
// memory port through a round-robin arbiter

`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module streamer (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  // Run control
  input  wire                        start_i,
  input  wire                        cast_i,
  input  wire  [`STREAM_ADDR_W-1:0]  x_base_i,
  input  wire  [`STREAM_ADDR_W-1:0]  w_base_i,
  input  wire  [`STREAM_ADDR_W-1:0]  y_base_i,
  input  wire  [`STREAM_ADDR_W-1:0]  z_base_i,
  input  wire  [`STREAM_LEN_W-1:0]   x_len_i,
  input  wire  [`STREAM_LEN_W-1:0]   w_len_i,
  input  wire  [`STREAM_LEN_W-1:0]   y_len_i,
  input  wire  [`STREAM_LEN_W-1:0]   z_len_i,
  output logic                       busy_o,
  output logic                       x_done_o,
  output logic                       w_done_o,
  output logic                       y_done_o,
  output logic                       z_done_o,
  // Engine streams
  output logic [`STREAM_DATA_W-1:0]  x_data_o,
  output logic                       x_valid_o,
  input  wire                        x_ready_i,
  output logic [`STREAM_DATA_W-1:0]  w_data_o,
  output logic                       w_valid_o,
  input  wire                        w_ready_i,
  output logic [`STREAM_DATA_W-1:0]  y_data_o,
  output logic                       y_valid_o,
  input  wire                        y_ready_i,
  input  wire  [`STREAM_DATA_W-1:0]  z_data_i,
  input  wire                        z_valid_i,
  output logic                       z_ready_o,
  // Memory port
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output logic [`STREAM_ADDR_W-1:0]  mem_addr_o,
  output logic [`STREAM_DATA_W-1:0]  mem_wdata_o,
  input  wire                        mem_gnt_i,
  input  wire                        mem_rvalid_i,
  input  wire  [`STREAM_DATA_W-1:0]  mem_rdata_i
);

  // Per-channel request groups indexed by stream_pkg::chan_e
  logic [3:0]                     ch_req;
  logic [3:0]                     ch_we;
  logic [3:0][`STREAM_ADDR_W-1:0] ch_addr;
  logic [3:0][`STREAM_DATA_W-1:0] ch_wdata;
  logic [3:0]                     ch_gnt;
  logic [3:0]                     ch_rvalid;
  logic [`STREAM_DATA_W-1:0]      rdata;
  logic                           x_busy;
  logic                           w_busy;
  logic                           y_busy;
  logic                           z_busy;
  logic                           start_go;

  // Whole-run busy
  // A start while any channel works is dropped
  assign busy_o   = x_busy | w_busy | y_busy | z_busy;
  assign start_go = start_i && !busy_o;

  // Load channels never write
  assign ch_we[stream_pkg::CH_X]    = 1'b0;
  assign ch_we[stream_pkg::CH_W]    = 1'b0;
  assign ch_we[stream_pkg::CH_Y]    = 1'b0;
  assign ch_wdata[stream_pkg::CH_X] = '0;
  assign ch_wdata[stream_pkg::CH_W] = '0;
  assign ch_wdata[stream_pkg::CH_Y] = '0;

  load_source u_x_src (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start_go), .cast_i(cast_i),
    .base_i(x_base_i), .len_i(x_len_i),
    .req_o(ch_req[stream_pkg::CH_X]), .addr_o(ch_addr[stream_pkg::CH_X]),
    .gnt_i(ch_gnt[stream_pkg::CH_X]), .rvalid_i(ch_rvalid[stream_pkg::CH_X]),
    .rdata_i(rdata), .data_o(x_data_o), .valid_o(x_valid_o), .ready_i(x_ready_i),
    .busy_o(x_busy), .done_o(x_done_o)
  );

  load_source u_w_src (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start_go), .cast_i(cast_i),
    .base_i(w_base_i), .len_i(w_len_i),
    .req_o(ch_req[stream_pkg::CH_W]), .addr_o(ch_addr[stream_pkg::CH_W]),
    .gnt_i(ch_gnt[stream_pkg::CH_W]), .rvalid_i(ch_rvalid[stream_pkg::CH_W]),
    .rdata_i(rdata), .data_o(w_data_o), .valid_o(w_valid_o), .ready_i(w_ready_i),
    .busy_o(w_busy), .done_o(w_done_o)
  );

  load_source u_y_src (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start_go), .cast_i(cast_i),
    .base_i(y_base_i), .len_i(y_len_i),
    .req_o(ch_req[stream_pkg::CH_Y]), .addr_o(ch_addr[stream_pkg::CH_Y]),
    .gnt_i(ch_gnt[stream_pkg::CH_Y]), .rvalid_i(ch_rvalid[stream_pkg::CH_Y]),
    .rdata_i(rdata), .data_o(y_data_o), .valid_o(y_valid_o), .ready_i(y_ready_i),
    .busy_o(y_busy), .done_o(y_done_o)
  );

  store_sink u_z_sink (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start_go), .cast_i(cast_i),
    .base_i(z_base_i), .len_i(z_len_i),
    .req_o(ch_req[stream_pkg::CH_Z]), .we_o(ch_we[stream_pkg::CH_Z]),
    .addr_o(ch_addr[stream_pkg::CH_Z]), .wdata_o(ch_wdata[stream_pkg::CH_Z]),
    .gnt_i(ch_gnt[stream_pkg::CH_Z]), .data_i(z_data_i), .valid_i(z_valid_i),
    .ready_o(z_ready_o), .busy_o(z_busy), .done_o(z_done_o)
  );

  mem_arbiter u_arb (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .req_i(ch_req), .we_i(ch_we), .addr_i(ch_addr), .wdata_i(ch_wdata),
    .gnt_o(ch_gnt), .rvalid_o(ch_rvalid), .rdata_o(rdata),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_wdata_o(mem_wdata_o), .mem_gnt_i(mem_gnt_i),
    .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i)
  );

endmodule

`default_nettype wire

// ==== tb_streamer.sv ====
// Streamer testbench
// Random memory with grant stalls, random engine ready and Z traffic
// Load beats and stored words are checked against a model of the cast rules

`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module tb_streamer;

  localparam int ROUNDS       = 20;
  localparam int ROUND_CYCLES = 2000;
  localparam int MEM_WORDS    = 1 << `STREAM_ADDR_W;
  // Each channel works in its own quarter of memory
  localparam int QUAD         = MEM_WORDS / 4;
  localparam int MAX_LEN      = 24;

  logic                      clk_i        = 1'b0;
  logic                      rst_n_i      = 1'b0;
  logic                      start_i      = 1'b0;
  logic                      cast_i       = 1'b0;
  logic [`STREAM_ADDR_W-1:0] x_base_i     = '0;
  logic [`STREAM_ADDR_W-1:0] w_base_i     = '0;
  logic [`STREAM_ADDR_W-1:0] y_base_i     = '0;
  logic [`STREAM_ADDR_W-1:0] z_base_i     = '0;
  logic [`STREAM_LEN_W-1:0]  x_len_i      = '0;
  logic [`STREAM_LEN_W-1:0]  w_len_i      = '0;
  logic [`STREAM_LEN_W-1:0]  y_len_i      = '0;
  logic [`STREAM_LEN_W-1:0]  z_len_i      = '0;
  logic                      x_ready_i    = 1'b0;
  logic                      w_ready_i    = 1'b0;
  logic                      y_ready_i    = 1'b0;
  logic [`STREAM_DATA_W-1:0] z_data_i     = '0;
  logic                      z_valid_i    = 1'b0;
  logic                      mem_gnt_i    = 1'b0;
  logic                      mem_rvalid_i = 1'b0;
  logic [`STREAM_DATA_W-1:0] mem_rdata_i  = '0;

  logic                      busy_o;
  logic                      x_done_o;
  logic                      w_done_o;
  logic                      y_done_o;
  logic                      z_done_o;
  logic [`STREAM_DATA_W-1:0] x_data_o;
  logic [`STREAM_DATA_W-1:0] w_data_o;
  logic [`STREAM_DATA_W-1:0] y_data_o;
  logic                      x_valid_o;
  logic                      w_valid_o;
  logic                      y_valid_o;
  logic                      z_ready_o;
  logic                      mem_req_o;
  logic                      mem_we_o;
  logic [`STREAM_ADDR_W-1:0] mem_addr_o;
  logic [`STREAM_DATA_W-1:0] mem_wdata_o;

  // Memory as the DUT sees it, and the model's copy
  logic [`STREAM_DATA_W-1:0] mem     [MEM_WORDS];
  logic [`STREAM_DATA_W-1:0] ref_mem [MEM_WORDS];

  // Expected load beats, Z beats sent so far
  logic [`STREAM_DATA_W-1:0] x_exp_q [$];
  logic [`STREAM_DATA_W-1:0] w_exp_q [$];
  logic [`STREAM_DATA_W-1:0] y_exp_q [$];
  logic [`STREAM_DATA_W-1:0] z_sent_q [$];

  // Round settings, channel index as in stream_pkg::chan_e
  logic cfg_cast = 1'b0;
  int   cfg_len [4];
  int   cfg_base [4];
  int   z_first = 0;
  int   z_target = 0;

  int   done_n [4] = '{0, 0, 0, 0};
  int   busy_fall_n = 0;
  logic busy_seen = 1'b0;
  logic z_moved;
  int   stream_errs = 0;
  int   round_errs = 0;

  streamer uut (.*);

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  // Memory model
  // Random grants, read data one cycle after the grant, writes on the grant
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int a = 0; a < MEM_WORDS; a++) mem[a] <= $urandom;
      mem_gnt_i    <= 1'b0;
      mem_rvalid_i <= 1'b0;
    end else begin
      mem_rvalid_i <= 1'b0;
      if (mem_req_o && mem_gnt_i) begin
        if (mem_we_o) begin
          mem[mem_addr_o] <= mem_wdata_o;
        end else begin
          mem_rdata_i  <= mem[mem_addr_o];
          mem_rvalid_i <= 1'b1;
        end
      end
      mem_gnt_i <= ($urandom % 10) < 7;
    end
  end

  // Compare one load beat with the head of its expected queue
  task automatic check_beat(input int ch, input string name, input logic [31:0] got);
    logic [31:0] exp_w;
    logic        have;
    have  = 1'b0;
    exp_w = '0;
    case (ch)
      0: if (x_exp_q.size() > 0) begin
        exp_w = x_exp_q.pop_front();
        have  = 1'b1;
      end
      1: if (w_exp_q.size() > 0) begin
        exp_w = w_exp_q.pop_front();
        have  = 1'b1;
      end
      default: if (y_exp_q.size() > 0) begin
        exp_w = y_exp_q.pop_front();
        have  = 1'b1;
      end
    endcase
    assert (have) else begin
      stream_errs++;
      $display("%s stream delivered a beat beyond its length at %0t", name, $time);
    end
    assert (!have || got == exp_w) else begin
      stream_errs++;
      $display("FAIL %0t: %s beat got %h expected %h", $time, name, got, exp_w);
    end
  endtask

  // Engine model
  // Random ready on loads, random Z beats, valid held until the beat moves
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      x_ready_i <= 1'b0;
      w_ready_i <= 1'b0;
      y_ready_i <= 1'b0;
      z_valid_i <= 1'b0;
    end else begin
      if (x_valid_o && x_ready_i) check_beat(0, "X", x_data_o);
      if (w_valid_o && w_ready_i) check_beat(1, "W", w_data_o);
      if (y_valid_o && y_ready_i) check_beat(2, "Y", y_data_o);
      x_ready_i <= ($urandom % 3) != 0;
      w_ready_i <= ($urandom % 3) != 0;
      y_ready_i <= ($urandom % 3) != 0;

      z_moved = z_valid_i && z_ready_o;
      if (z_moved) z_sent_q.push_back(z_data_i);
      if (!z_valid_i || z_moved) begin
        if (z_sent_q.size() - z_first < z_target && ($urandom % 4) != 0) begin
          z_valid_i <= 1'b1;
          z_data_i  <= $urandom;
        end else begin
          z_valid_i <= 1'b0;
        end
      end

      if (x_done_o) done_n[0]++;
      if (w_done_o) done_n[1]++;
      if (y_done_o) done_n[2]++;
      if (z_done_o) done_n[3]++;
      // Every channel must have finished once by the time busy drops
      if (busy_seen && !busy_o) begin
        busy_fall_n++;
        for (int c = 0; c < 4; c++) begin
          assert (done_n[c] == busy_fall_n) else begin
            stream_errs++;
            $display("busy_o fell before channel %0d finished at %0t", c, $time);
          end
        end
      end
      busy_seen = busy_o;
    end
  end

  // Random settings in disjoint quarters, then the expected load beats
  task automatic plan_round();
    stream_pkg::mem_word_u w;
    stream_pkg::mem_word_u b;
    cfg_cast = 1'($urandom % 2);
    for (int c = 0; c < 4; c++) begin
      cfg_len[c]  = 1 + int'($urandom % MAX_LEN);
      cfg_base[c] = c * QUAD + int'($urandom % (QUAD - cfg_len[c] + 1));
    end
    for (int c = 0; c < 3; c++) begin
      for (int i = 0; i < cfg_len[c]; i++) begin
        w = ref_mem[cfg_base[c] + i];
        for (int h = 0; h < (cfg_cast ? 2 : 1); h++) begin
          b = w;
          if (cfg_cast) begin
            b.fp16[0] = {w.fp8[2*h], 8'h00};
            b.fp16[1] = {w.fp8[2*h+1], 8'h00};
          end
          if (c == 0) x_exp_q.push_back(b);
          else if (c == 1) w_exp_q.push_back(b);
          else y_exp_q.push_back(b);
        end
      end
    end
  endtask

  // End of round: counts, Z packing into the model copy, whole memory
  task automatic check_round(input int r);
    stream_pkg::mem_word_u w;
    stream_pkg::mem_word_u lo;
    stream_pkg::mem_word_u hi;
    assert (x_exp_q.size() == 0 && w_exp_q.size() == 0 && y_exp_q.size() == 0) else begin
      round_errs++;
      $display("Round %0d: a load stream stopped short of its length", r);
    end
    for (int c = 0; c < 4; c++) begin
      assert (done_n[c] == r + 1) else begin
        round_errs++;
        $display("Round %0d: channel %0d done pulsed %0d times in total", r, c, done_n[c]);
      end
    end
    assert (busy_fall_n == r + 1) else begin
      round_errs++;
      $display("Round %0d: busy_o fell %0d times in total", r, busy_fall_n);
    end
    assert (z_sent_q.size() - z_first == z_target) else begin
      round_errs++;
      $display("Round %0d: Z took %0d beats instead of %0d", r,
               z_sent_q.size() - z_first, z_target);
    end
    for (int i = 0; i < cfg_len[3]; i++) begin
      if (!cfg_cast) begin
        w = z_sent_q[z_first + i];
      end else begin
        lo = z_sent_q[z_first + 2*i];
        hi = z_sent_q[z_first + 2*i + 1];
        w.fp8[0] = lo.fp16[0][15:8];
        w.fp8[1] = lo.fp16[1][15:8];
        w.fp8[2] = hi.fp16[0][15:8];
        w.fp8[3] = hi.fp16[1][15:8];
      end
      ref_mem[cfg_base[3] + i] = w;
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      assert (mem[a] === ref_mem[a]) else begin
        round_errs++;
        $display("FAIL %0t: memory word %h is %h expected %h", $time, a, mem[a], ref_mem[a]);
      end
    end
  endtask

  initial begin
    void'($urandom(87305));
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    for (int a = 0; a < MEM_WORDS; a++) ref_mem[a] = mem[a];

    for (int r = 0; r < ROUNDS; r++) begin
      plan_round();
      z_first  = z_sent_q.size();
      z_target = cfg_cast ? 2 * cfg_len[3] : cfg_len[3];
      @(posedge clk_i);
      start_i  <= 1'b1;
      cast_i   <= cfg_cast;
      x_base_i <= `STREAM_ADDR_W'(cfg_base[0]);
      w_base_i <= `STREAM_ADDR_W'(cfg_base[1]);
      y_base_i <= `STREAM_ADDR_W'(cfg_base[2]);
      z_base_i <= `STREAM_ADDR_W'(cfg_base[3]);
      x_len_i  <= `STREAM_LEN_W'(cfg_len[0]);
      w_len_i  <= `STREAM_LEN_W'(cfg_len[1]);
      y_len_i  <= `STREAM_LEN_W'(cfg_len[2]);
      z_len_i  <= `STREAM_LEN_W'(cfg_len[3]);
      @(posedge clk_i);
      start_i <= 1'b0;
      @(posedge clk_i);
      assert (busy_o) else begin
        round_errs++;
        $display("Round %0d: busy_o did not rise after start_i", r);
      end
      // Second start while busy, its settings must be dropped
      start_i  <= 1'b1;
      cast_i   <= !cfg_cast;
      x_base_i <= `STREAM_ADDR_W'($urandom);
      z_base_i <= `STREAM_ADDR_W'($urandom);
      z_len_i  <= `STREAM_LEN_W'($urandom);
      @(posedge clk_i);
      start_i <= 1'b0;
      while (busy_o) @(posedge clk_i);
      repeat (2) @(posedge clk_i);
      check_round(r);
    end

    $display("Errors: %0d in streams, %0d in round checks", stream_errs, round_errs);
    if (stream_errs == 0 && round_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog sized for all rounds at their worst case
  initial begin
    repeat (ROUNDS * ROUND_CYCLES) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", ROUNDS * ROUND_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
stream_pkg.sv
mem_arbiter.sv
load_source.sv
store_sink.sv
streamer.sv
tb_streamer.sv

// ==== Makefile ====
# Verilator build and run of the streamer testbench

VERILATOR ?= verilator
TOP       ?= tb_streamer
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) stream_consts.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
